// File: source/xlate_pkg.sv
/*
 * Shared widths, depths and the splitter state encoding for the
 * address-translation request engine. Modules import it inside their body
 * and use scoped names in their port lists.
 */
package xlate_pkg;

    // ------------------------------
    // Address and request fields
    // ------------------------------
    localparam int vaddr_bits = 32;
    localparam int paddr_bits = 32;
    localparam int len_bits   = 20;
    localparam int pid_bits   = 4;

    // Single page size of 4 KiB
    localparam int page_bits = 12;
    localparam int page_size = 1 << page_bits;
    localparam int vpn_bits  = vaddr_bits - page_bits;
    localparam int ppn_bits  = paddr_bits - page_bits;

    // ------------------------------
    // TLB geometry
    // ------------------------------
    localparam int tlb_index_bits = 4;
    localparam int tlb_entries    = 1 << tlb_index_bits;
    localparam int tlb_tag_bits   = vpn_bits - tlb_index_bits;

    // ------------------------------
    // Queues
    // ------------------------------
    localparam int req_queue_depth = 4;
    localparam int max_outstanding = 8;

    // Request entry is {vaddr, len, pid}
    localparam int req_width = vaddr_bits + len_bits + pid_bits;
    // Outstanding chunk record is {pid, last}
    localparam int ack_width = pid_bits + 1;

    // Splitter FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_CALC,
        ST_SEND
    } splitter_state_e;

endpackage

// File: source/sync_fifo.sv
/*
 * Synchronous circular FIFO with push and pop strobes.
 * The head entry is visible combinationally on pop_data. A push while full
 * and a pop while empty are ignored. Used for the request queue and for
 * the outstanding-chunk queue.
 */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int depth = 4,
    parameter int width = 8
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             push,
    input  logic [width-1:0] push_data,
    input  logic             pop,
    output logic [width-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    logic [width-1:0]             mem [depth];
    logic [$clog2(depth)-1:0]     wr_ptr;
    logic [$clog2(depth)-1:0]     rd_ptr;
    logic [$clog2(depth+1)-1:0]   count;
    logic                         do_push;
    logic                         do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (int'(count) == depth);
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: source/page_tlb.sv
/*
 * Direct-mapped TLB, indexed by the low virtual page bits.
 * Entries are filled through the write port. A lookup compares tag and
 * process id and returns hit and ppn one cycle later.
 */
`timescale 1ns/1ps

module page_tlb (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          tlb_wr,
    input  logic [xlate_pkg::pid_bits-1:0] tlb_pid,
    input  logic [xlate_pkg::vpn_bits-1:0] tlb_vpn,
    input  logic [xlate_pkg::ppn_bits-1:0] tlb_ppn,
    input  logic [xlate_pkg::vpn_bits-1:0] lookup_vpn,
    input  logic [xlate_pkg::pid_bits-1:0] lookup_pid,
    output logic                          hit,
    output logic [xlate_pkg::ppn_bits-1:0] ppn
);

    import xlate_pkg::*;

    // Entry fields
    logic [tlb_entries-1:0]  entry_valid;
    logic [tlb_tag_bits-1:0] entry_tag [tlb_entries];
    logic [pid_bits-1:0]     entry_pid [tlb_entries];
    logic [ppn_bits-1:0]     entry_ppn [tlb_entries];

    logic [tlb_index_bits-1:0] wr_index;
    logic [tlb_index_bits-1:0] rd_index;
    logic [tlb_tag_bits-1:0]   rd_tag;

    assign wr_index = tlb_vpn[tlb_index_bits-1:0];
    assign rd_index = lookup_vpn[tlb_index_bits-1:0];
    assign rd_tag   = lookup_vpn[vpn_bits-1:tlb_index_bits];

    // ------------------------------
    // Fill and valid bits
    // ------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            entry_valid <= '0;
        end else if (tlb_wr) begin
            entry_valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (tlb_wr) begin
            entry_tag[wr_index] <= tlb_vpn[vpn_bits-1:tlb_index_bits];
            entry_pid[wr_index] <= tlb_pid;
            entry_ppn[wr_index] <= tlb_ppn;
        end
    end

    // ------------------------------
    // Registered lookup
    // ------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hit <= 1'b0;
        end else begin
            hit <= entry_valid[rd_index] && (entry_tag[rd_index] == rd_tag)
                && (entry_pid[rd_index] == lookup_pid);
        end
    end

    always_ff @(posedge aclk) begin
        ppn <= entry_ppn[rd_index];
    end

endmodule

// File: source/page_splitter.sv
/*
 * Request splitter FSM. Pops a virtual request from the queue, translates
 * it page by page through the TLB and issues one page-bounded DMA chunk per
 * page. A miss reports a page fault and drops the rest of the request.
 * Chunk issue stalls while the outstanding-chunk queue is full.
 */
`timescale 1ns/1ps

module page_splitter (
    input  logic                             aclk,
    input  logic                             aresetn,
    // Request queue
    input  logic                             req_empty,
    input  logic [xlate_pkg::req_width-1:0]  req_data,
    output logic                             req_pop,
    // TLB lookup
    output logic [xlate_pkg::vpn_bits-1:0]   lookup_vpn,
    output logic [xlate_pkg::pid_bits-1:0]   lookup_pid,
    input  logic                             hit,
    input  logic [xlate_pkg::ppn_bits-1:0]   ppn,
    // Tracker back-pressure
    input  logic                             ack_full,
    // DMA chunks
    output logic                             dma_valid,
    output logic [xlate_pkg::paddr_bits-1:0] dma_paddr,
    output logic [xlate_pkg::len_bits-1:0]   dma_len,
    output logic                             dma_last,
    // Page fault
    output logic                             pfault_valid,
    output logic [xlate_pkg::vaddr_bits-1:0] pfault_vaddr,
    output logic [xlate_pkg::pid_bits-1:0]   pfault_pid
);

    import xlate_pkg::*;

    splitter_state_e state;

    // Current request
    logic [vaddr_bits-1:0] vaddr_q;
    logic [len_bits-1:0]   rem_q;
    logic [pid_bits-1:0]   pid_q;

    // Queue entry fields
    logic [vaddr_bits-1:0] head_vaddr;
    logic [len_bits-1:0]   head_len;
    logic [pid_bits-1:0]   head_pid;

    // Page split terms
    logic [page_bits-1:0]  offset;
    logic [len_bits-1:0]   head_room;

    assign head_vaddr = req_data[req_width-1 -: vaddr_bits];
    assign head_len   = req_data[pid_bits +: len_bits];
    assign head_pid   = req_data[pid_bits-1:0];

    assign offset    = vaddr_q[page_bits-1:0];
    assign head_room = len_bits'(page_size) - len_bits'(offset);

    assign req_pop    = (state == ST_IDLE) && !req_empty;
    assign lookup_vpn = vaddr_q[vaddr_bits-1:page_bits];
    assign lookup_pid = pid_q;
    assign dma_valid  = (state == ST_SEND) && !ack_full;

    // Vaddr does not advance on a miss, so it still names the faulting page
    assign pfault_vaddr = vaddr_q;
    assign pfault_pid   = pid_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state        <= ST_IDLE;
            pfault_valid <= 1'b0;
        end else begin
            pfault_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!req_empty) begin
                        vaddr_q <= head_vaddr;
                        rem_q   <= head_len;
                        pid_q   <= head_pid;
                        // Zero length is popped and discarded
                        if (head_len != '0) begin
                            state <= ST_LOOKUP;
                        end
                    end
                end

                // TLB result arrives next cycle
                ST_LOOKUP: begin
                    state <= ST_CALC;
                end

                ST_CALC: begin
                    if (!hit) begin
                        pfault_valid <= 1'b1;
                        state        <= ST_IDLE;
                    end else begin
                        dma_paddr <= {ppn, offset};
                        if (rem_q > head_room) begin
                            // Crosses the page boundary
                            dma_len  <= head_room;
                            dma_last <= 1'b0;
                            rem_q    <= rem_q - head_room;
                            vaddr_q  <= vaddr_q + vaddr_bits'(head_room);
                        end else begin
                            dma_len  <= rem_q;
                            dma_last <= 1'b1;
                            rem_q    <= '0;
                        end
                        state <= ST_SEND;
                    end
                end

                ST_SEND: begin
                    if (!ack_full) begin
                        state <= (rem_q != '0) ? ST_LOOKUP : ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: source/completion_tracker.sv
/*
 * Outstanding DMA chunk tracker. Each issued chunk pushes a {pid, last}
 * record, each DMA done pops one in issue order. A popped record marked
 * last produces a request completion on the next cycle.
 */
`timescale 1ns/1ps

module completion_tracker (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           dma_valid,
    input  logic [xlate_pkg::pid_bits-1:0] dma_pid,
    input  logic                           dma_last,
    input  logic                           dma_done,
    output logic                           full,
    output logic                           cmpl_valid,
    output logic [xlate_pkg::pid_bits-1:0] cmpl_pid
);

    import xlate_pkg::*;

    logic [ack_width-1:0] ack_head;
    logic                 ack_empty;

    sync_fifo #(
        .depth(max_outstanding),
        .width(ack_width)
    ) ack_queue (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .push      (dma_valid),
        .push_data ({dma_pid, dma_last}),
        .pop       (dma_done),
        .pop_data  (ack_head),
        .full      (full),
        .empty     (ack_empty)
    );

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cmpl_valid <= 1'b0;
        end else begin
            cmpl_valid <= dma_done && !ack_empty && ack_head[0];
        end
    end

    always_ff @(posedge aclk) begin
        cmpl_pid <= ack_head[ack_width-1:1];
    end

endmodule

// File: source/xlate_top.sv
/*
 * Top level of the address-translation request engine.
 * Connects the request queue, the TLB, the page splitter and the
 * completion tracker. All handshakes are single-cycle strobes.
 */
`timescale 1ns/1ps

module xlate_top (
    input  logic                             aclk,
    input  logic                             aresetn,
    // Virtual requests
    input  logic                             req_valid,
    input  logic [xlate_pkg::vaddr_bits-1:0] req_vaddr,
    input  logic [xlate_pkg::len_bits-1:0]   req_len,
    input  logic [xlate_pkg::pid_bits-1:0]   req_pid,
    output logic                             req_overflow,
    // TLB fill
    input  logic                             tlb_wr,
    input  logic [xlate_pkg::pid_bits-1:0]   tlb_pid,
    input  logic [xlate_pkg::vpn_bits-1:0]   tlb_vpn,
    input  logic [xlate_pkg::ppn_bits-1:0]   tlb_ppn,
    // DMA chunks and completions
    output logic                             dma_valid,
    output logic [xlate_pkg::paddr_bits-1:0] dma_paddr,
    output logic [xlate_pkg::len_bits-1:0]   dma_len,
    output logic                             dma_last,
    input  logic                             dma_done,
    // Page fault and request completion
    output logic                             pfault_valid,
    output logic [xlate_pkg::vaddr_bits-1:0] pfault_vaddr,
    output logic [xlate_pkg::pid_bits-1:0]   pfault_pid,
    output logic                             cmpl_valid,
    output logic [xlate_pkg::pid_bits-1:0]   cmpl_pid
);

    import xlate_pkg::*;

    logic [req_width-1:0] req_head;
    logic                 req_full;
    logic                 req_empty;
    logic                 req_pop;
    logic [vpn_bits-1:0]  lookup_vpn;
    logic [pid_bits-1:0]  lookup_pid;
    logic                 tlb_hit;
    logic [ppn_bits-1:0]  tlb_ppn_q;
    logic                 ack_full;

    // Dropped request flag
    assign req_overflow = req_valid && req_full;

    sync_fifo #(
        .depth(req_queue_depth),
        .width(req_width)
    ) req_queue (
        .aclk(aclk), .aresetn(aresetn),
        .push(req_valid), .push_data({req_vaddr, req_len, req_pid}),
        .pop(req_pop), .pop_data(req_head),
        .full(req_full), .empty(req_empty)
    );

    page_tlb tlb (
        .aclk(aclk), .aresetn(aresetn),
        .tlb_wr(tlb_wr), .tlb_pid(tlb_pid), .tlb_vpn(tlb_vpn), .tlb_ppn(tlb_ppn),
        .lookup_vpn(lookup_vpn), .lookup_pid(lookup_pid),
        .hit(tlb_hit), .ppn(tlb_ppn_q)
    );

    page_splitter splitter (
        .aclk(aclk), .aresetn(aresetn),
        .req_empty(req_empty), .req_data(req_head), .req_pop(req_pop),
        .lookup_vpn(lookup_vpn), .lookup_pid(lookup_pid),
        .hit(tlb_hit), .ppn(tlb_ppn_q), .ack_full(ack_full),
        .dma_valid(dma_valid), .dma_paddr(dma_paddr),
        .dma_len(dma_len), .dma_last(dma_last),
        .pfault_valid(pfault_valid), .pfault_vaddr(pfault_vaddr),
        .pfault_pid(pfault_pid)
    );

    // Splitter pid is stable while a chunk is issued
    completion_tracker tracker (
        .aclk(aclk), .aresetn(aresetn),
        .dma_valid(dma_valid), .dma_pid(lookup_pid), .dma_last(dma_last),
        .dma_done(dma_done), .full(ack_full),
        .cmpl_valid(cmpl_valid), .cmpl_pid(cmpl_pid)
    );

endmodule

// File: test/xlate_assert.sv
/*
 * Concurrent checks bound into the FIFO, the page splitter and the
 * completion tracker. Inputs that a bound instance does not use are tied low.
 */
`timescale 1ns/1ps

module xlate_assert (
    input logic       aclk,
    input logic       aresetn,
    input logic       pop,
    input logic       empty,
    input logic       dma_valid,
    input logic [1:0] state,
    input logic       chunk_push,
    input logic       dma_done,
    input logic       ack_empty
);

    import xlate_pkg::*;

    // Chunks seen at the tracker ports and not yet retired
    int outstanding;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            outstanding <= 0;
        end else if (chunk_push && !(dma_done && outstanding > 0)) begin
            outstanding <= outstanding + 1;
        end else if (!chunk_push && dma_done && outstanding > 0) begin
            outstanding <= outstanding - 1;
        end
    end

    no_pop_when_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        pop |-> !empty)
        else $error("FIFO pop while empty");

    // Chunks leave ST_SEND only after ST_CALC or a stalled ST_SEND
    chunk_only_in_send: assert property (@(posedge aclk) disable iff (!aresetn)
        dma_valid |-> ($past(state) == ST_CALC) || ($past(state) == ST_SEND))
        else $error("DMA chunk issued outside ST_SEND");

    chunk_within_limit: assert property (@(posedge aclk) disable iff (!aresetn)
        chunk_push |-> outstanding < max_outstanding)
        else $error("DMA chunk issued while the tracker was full");

    done_needs_record: assert property (@(posedge aclk) disable iff (!aresetn)
        dma_done |-> !ack_empty)
        else $error("DMA done with no outstanding chunk");

endmodule

bind sync_fifo xlate_assert fifo_checks (
    .aclk(aclk), .aresetn(aresetn), .pop(pop), .empty(empty),
    .dma_valid(1'b0), .state(2'b00), .chunk_push(1'b0),
    .dma_done(1'b0), .ack_empty(1'b0)
);

bind page_splitter xlate_assert splitter_checks (
    .aclk(aclk), .aresetn(aresetn), .pop(1'b0), .empty(1'b0),
    .dma_valid(dma_valid), .state(state), .chunk_push(1'b0),
    .dma_done(1'b0), .ack_empty(1'b0)
);

bind completion_tracker xlate_assert tracker_checks (
    .aclk(aclk), .aresetn(aresetn), .pop(1'b0), .empty(1'b0),
    .dma_valid(1'b0), .state(2'b00), .chunk_push(dma_valid),
    .dma_done(dma_done), .ack_empty(ack_empty)
);

// File: test/tb_xlate.sv
/*
 * Directed testbench for the address-translation request engine.
 * Fills the TLB, sends virtual requests, retires DMA chunks and compares
 * chunks, page faults and completions with a model of the split rules.
 */
`timescale 1ns/1ps

module tb_xlate;

    import xlate_pkg::*;

    // Cycle budget of reset and the six tests
    localparam int test_cycles    = 20 + 60 + 150 + 200 + 100 + 150 + 200;
    localparam int timeout_cycles = 2 * test_cycles;

    logic                  aclk;
    logic                  aresetn;
    logic                  req_valid;
    logic [vaddr_bits-1:0] req_vaddr;
    logic [len_bits-1:0]   req_len;
    logic [pid_bits-1:0]   req_pid;
    logic                  req_overflow;
    logic                  tlb_wr;
    logic [pid_bits-1:0]   tlb_pid;
    logic [vpn_bits-1:0]   tlb_vpn;
    logic [ppn_bits-1:0]   tlb_ppn;
    logic                  dma_valid;
    logic [paddr_bits-1:0] dma_paddr;
    logic [len_bits-1:0]   dma_len;
    logic                  dma_last;
    logic                  dma_done;
    logic                  pfault_valid;
    logic [vaddr_bits-1:0] pfault_vaddr;
    logic [pid_bits-1:0]   pfault_pid;
    logic                  cmpl_valid;
    logic [pid_bits-1:0]   cmpl_pid;

    // Expected TLB contents
    logic                m_valid [tlb_entries];
    logic [vpn_bits-1:0] m_vpn   [tlb_entries];
    logic [pid_bits-1:0] m_pid   [tlb_entries];
    logic [ppn_bits-1:0] m_ppn   [tlb_entries];

    // Observed strobes
    logic [paddr_bits-1:0] got_paddr  [$];
    logic [len_bits-1:0]   got_len    [$];
    logic                  got_last   [$];
    logic [vaddr_bits-1:0] got_fvaddr [$];
    logic [pid_bits-1:0]   got_fpid   [$];
    logic [pid_bits-1:0]   got_cpid   [$];
    int                    ovf_count = 0;

    // Expected strobes
    logic [paddr_bits-1:0] exp_paddr  [$];
    logic [len_bits-1:0]   exp_len    [$];
    logic                  exp_last   [$];
    logic [vaddr_bits-1:0] exp_fvaddr [$];
    logic [pid_bits-1:0]   exp_fpid   [$];
    logic [pid_bits-1:0]   exp_cpid   [$];

    int     dma_base;
    int     pf_base;
    int     cmpl_base;
    int     ovf_base;
    int     retired;
    int     errors;
    int     timeouts;
    int     cycle_count = 0;
    integer seed;

    xlate_top xlate_top_inst (
        .aclk(aclk), .aresetn(aresetn),
        .req_valid(req_valid), .req_vaddr(req_vaddr), .req_len(req_len),
        .req_pid(req_pid), .req_overflow(req_overflow),
        .tlb_wr(tlb_wr), .tlb_pid(tlb_pid), .tlb_vpn(tlb_vpn), .tlb_ppn(tlb_ppn),
        .dma_valid(dma_valid), .dma_paddr(dma_paddr), .dma_len(dma_len),
        .dma_last(dma_last), .dma_done(dma_done),
        .pfault_valid(pfault_valid), .pfault_vaddr(pfault_vaddr),
        .pfault_pid(pfault_pid), .cmpl_valid(cmpl_valid), .cmpl_pid(cmpl_pid)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // Strobes are sampled mid-cycle
    always @(negedge aclk) begin
        if (aresetn) begin
            if (dma_valid) begin
                got_paddr.push_back(dma_paddr);
                got_len.push_back(dma_len);
                got_last.push_back(dma_last);
            end
            if (pfault_valid) begin
                got_fvaddr.push_back(pfault_vaddr);
                got_fpid.push_back(pfault_pid);
            end
            if (cmpl_valid) begin
                got_cpid.push_back(cmpl_pid);
            end
            if (req_overflow) begin
                ovf_count = ovf_count + 1;
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            timeouts = timeouts + 1;
            $display("Timed out after %0d cycles waiting for the DUT", cycle_count);
            $display("Errors: %0d failed check(s), %0d timeout(s)", errors, timeouts);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic step();
        @(posedge aclk);
        #1;
    endtask

    task automatic settle(input int n);
        repeat (n) step();
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL @%0t: %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic fill_tlb(input logic [pid_bits-1:0] pid, input logic [vpn_bits-1:0] vpn,
                            input logic [ppn_bits-1:0] ppn);
        int idx;
        idx = int'(vpn[tlb_index_bits-1:0]);
        step();
        tlb_wr  = 1'b1;
        tlb_pid = pid;
        tlb_vpn = vpn;
        tlb_ppn = ppn;
        step();
        tlb_wr = 1'b0;
        m_valid[idx] = 1'b1;
        m_vpn[idx]   = vpn;
        m_pid[idx]   = pid;
        m_ppn[idx]   = ppn;
    endtask

    task automatic send_req(input logic [vaddr_bits-1:0] vaddr,
                            input logic [len_bits-1:0] len, input logic [pid_bits-1:0] pid);
        step();
        req_valid = 1'b1;
        req_vaddr = vaddr;
        req_len   = len;
        req_pid   = pid;
        step();
        req_valid = 1'b0;
    endtask

    // Page split model where a chunk ends at a page boundary and a miss ends the request
    task automatic expect_request(input logic [vaddr_bits-1:0] vaddr,
                                  input logic [len_bits-1:0] len,
                                  input logic [pid_bits-1:0] pid);
        logic [vaddr_bits-1:0] va;
        logic [vpn_bits-1:0]   vpn;
        int                    rem;
        int                    room;
        int                    chunk;
        int                    idx;
        va  = vaddr;
        rem = int'(len);
        while (rem > 0) begin
            vpn  = va[vaddr_bits-1:page_bits];
            idx  = int'(vpn[tlb_index_bits-1:0]);
            room = page_size - int'(va[page_bits-1:0]);
            if (!(m_valid[idx] && m_vpn[idx] == vpn && m_pid[idx] == pid)) begin
                exp_fvaddr.push_back(va);
                exp_fpid.push_back(pid);
                return;
            end
            chunk = (rem > room) ? room : rem;
            exp_paddr.push_back({m_ppn[idx], va[page_bits-1:0]});
            exp_len.push_back(len_bits'(chunk));
            exp_last.push_back(rem == chunk);
            rem = rem - chunk;
            va  = va + 32'(chunk);
        end
        if (len != '0) begin
            exp_cpid.push_back(pid);
        end
    endtask

    task automatic start_test();
        exp_paddr.delete();
        exp_len.delete();
        exp_last.delete();
        exp_fvaddr.delete();
        exp_fpid.delete();
        exp_cpid.delete();
        dma_base  = got_paddr.size();
        pf_base   = got_fvaddr.size();
        cmpl_base = got_cpid.size();
        ovf_base  = ovf_count;
        retired   = 0;
    endtask

    task automatic wait_outputs();
        while ((got_paddr.size() - dma_base < exp_paddr.size())
               || (got_fvaddr.size() - pf_base < exp_fvaddr.size())) begin
            step();
        end
    endtask

    task automatic wait_chunks(input int n);
        while (got_paddr.size() - dma_base < n) step();
    endtask

    task automatic wait_cmpls(input int n);
        while (got_cpid.size() - cmpl_base < n) step();
    endtask

    // One dma_done per issued chunk until target chunks of this test are retired
    task automatic drain(input int target);
        while (retired < target) begin
            step();
            if (got_paddr.size() - dma_base > retired) begin
                dma_done = 1'b1;
                retired  = retired + 1;
            end else begin
                dma_done = 1'b0;
            end
        end
        step();
        dma_done = 1'b0;
    endtask

    task automatic verify_outputs();
        check_value("chunk count", got_paddr.size() - dma_base, exp_paddr.size());
        check_value("fault count", got_fvaddr.size() - pf_base, exp_fvaddr.size());
        check_value("completion count", got_cpid.size() - cmpl_base, exp_cpid.size());
        foreach (exp_paddr[i]) begin
            if (dma_base + i < got_paddr.size()) begin
                check_value($sformatf("chunk %0d paddr", i), got_paddr[dma_base + i],
                            exp_paddr[i]);
                check_value($sformatf("chunk %0d len", i), 32'(got_len[dma_base + i]),
                            32'(exp_len[i]));
                check_value($sformatf("chunk %0d last", i), 32'(got_last[dma_base + i]),
                            32'(exp_last[i]));
            end
        end
        foreach (exp_fvaddr[i]) begin
            if (pf_base + i < got_fvaddr.size()) begin
                check_value("fault vaddr", got_fvaddr[pf_base + i], exp_fvaddr[i]);
                check_value("fault pid", 32'(got_fpid[pf_base + i]), 32'(exp_fpid[i]));
            end
        end
        foreach (exp_cpid[i]) begin
            if (cmpl_base + i < got_cpid.size()) begin
                check_value("completion pid", 32'(got_cpid[cmpl_base + i]),
                            32'(exp_cpid[i]));
            end
        end
    endtask

    task automatic run_request(input logic [vaddr_bits-1:0] vaddr,
                               input logic [len_bits-1:0] len, input logic [pid_bits-1:0] pid);
        start_test();
        expect_request(vaddr, len, pid);
        send_req(vaddr, len, pid);
        wait_outputs();
        settle(4);
        drain(exp_paddr.size());
        wait_cmpls(exp_cpid.size());
        settle(4);
        verify_outputs();
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic single_page_hit();
        fill_tlb(4'd3, 20'h00010, 20'h000a5);
        run_request(32'h0001_0100, 20'h00200, 4'd3);
    endtask

    task automatic page_crossing_split();
        logic [len_bits-1:0] len;
        int                  sum;
        for (int i = 0; i < 4; i++) begin
            fill_tlb(4'd5, 20'(32'h20 + i), 20'(32'h100 + 7 * i));
        end
        repeat (2) begin
            len = len_bits'(5000 + ($unsigned($random(seed)) % 8000));
            run_request(32'h0002_0a40, len, 4'd5);
            sum = 0;
            for (int i = dma_base; i < got_paddr.size(); i++) begin
                sum = sum + int'(got_len[i]);
            end
            check_value("chunk length sum", sum, int'(len));
        end
    endtask

    task automatic miss_and_pid();
        run_request(32'h0004_0010, 20'h00100, 4'd2);
        fill_tlb(4'd6, 20'h00041, 20'h00777);
        run_request(32'h0004_1000, 20'h00080, 4'd7);
        // First page translates and the next one misses
        run_request(32'h0004_1f00, 20'h00300, 4'd6);
    endtask

    task automatic completion_order();
        fill_tlb(4'd8, 20'h00050, 20'h00500);
        fill_tlb(4'd8, 20'h00051, 20'h00501);
        fill_tlb(4'd9, 20'h00052, 20'h00502);
        start_test();
        expect_request(32'h0005_0800, 20'h01000, 4'd8);
        expect_request(32'h0005_2000, 20'h00400, 4'd9);
        send_req(32'h0005_0800, 20'h01000, 4'd8);
        send_req(32'h0005_2000, 20'h00400, 4'd9);
        wait_outputs();
        drain(1);
        settle(4);
        check_value("completions before last chunk", got_cpid.size() - cmpl_base, 0);
        drain(2);
        wait_cmpls(1);
        settle(4);
        check_value("completions after first request", got_cpid.size() - cmpl_base, 1);
        drain(3);
        wait_cmpls(2);
        settle(4);
        verify_outputs();
    endtask

    task automatic outstanding_limit();
        for (int i = 0; i < 10; i++) begin
            fill_tlb(4'd10, 20'(32'h60 + i), 20'(32'h600 + i));
        end
        start_test();
        expect_request(32'h0006_0000, 20'(10 * page_size), 4'd10);
        send_req(32'h0006_0000, 20'(10 * page_size), 4'd10);
        wait_chunks(max_outstanding);
        settle(12);
        check_value("chunks while stalled", got_paddr.size() - dma_base, max_outstanding);
        drain(exp_paddr.size());
        wait_cmpls(exp_cpid.size());
        settle(4);
        verify_outputs();
    endtask

    task automatic queue_overflow();
        logic [vaddr_bits-1:0] vaddr;
        logic [len_bits-1:0]   len;
        start_test();
        expect_request(32'h0006_0000, 20'(10 * page_size), 4'd10);
        send_req(32'h0006_0000, 20'(10 * page_size), 4'd10);
        wait_chunks(max_outstanding);
        settle(4);
        // Splitter is stalled so the fifth request finds the queue full
        for (int k = 0; k < 5; k++) begin
            vaddr = 32'h0006_0000 + 32'(k * page_size);
            len   = len_bits'(64 * (k + 1));
            if (k < req_queue_depth) begin
                expect_request(vaddr, len, 4'd10);
            end
            send_req(vaddr, len, 4'd10);
        end
        settle(4);
        check_value("overflow strobes", ovf_count - ovf_base, 1);
        drain(exp_paddr.size());
        wait_cmpls(exp_cpid.size());
        settle(4);
        verify_outputs();
    endtask

    initial begin
        seed      = 43420;
        errors    = 0;
        timeouts  = 0;
        aresetn   = 1'b0;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_len   = '0;
        req_pid   = '0;
        tlb_wr    = 1'b0;
        tlb_pid   = '0;
        tlb_vpn   = '0;
        tlb_ppn   = '0;
        dma_done  = 1'b0;
        foreach (m_valid[i]) begin
            m_valid[i] = 1'b0;
        end
        repeat (16) @(posedge aclk);
        #1 aresetn = 1'b1;
        check_value("strobes after reset",
                    {28'b0, dma_valid, pfault_valid, cmpl_valid, req_overflow}, 0);

        single_page_hit();
        page_crossing_split();
        miss_and_pid();
        completion_order();
        outstanding_limit();
        queue_overflow();

        $display("Errors: %0d failed check(s), %0d timeout(s)", errors, timeouts);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
source/xlate_pkg.sv
source/sync_fifo.sv
source/page_tlb.sv
source/page_splitter.sv
source/completion_tracker.sv
source/xlate_top.sv
test/xlate_assert.sv
test/tb_xlate.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the translation engine testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_xlate -f sources.f

./obj_dir/Vtb_xlate | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: testbench reported success"
    exit 0
else
    echo "run_sim: testbench reported failure"
    exit 1
fi
